/* design/bpu_cfg_pkg.sv */
package bpu_cfg_pkg;

    // fetch address width
    localparam int XLEN = 32;

    // one fetch block spans this many bytes
    localparam int BLOCK_BYTES = 16;

    // byte offset bits inside a block
    localparam int BLOCK_SHIFT = $clog2(BLOCK_BYTES);

    // block address bits kept as the uBTB tag
    localparam int TAG_W = XLEN - BLOCK_SHIFT;

    // reset vector of the core
    localparam logic [XLEN-1:0] DEFAULT_INIT_PC = 32'h8000_0000;

endpackage

/* design/bpu_types_pkg.sv */
package bpu_types_pkg;

    // kind of control transfer that closes a fetch block
    typedef enum logic [1:0] {
        BR_NONE     = 2'd0,
        BR_COND     = 2'd1,
        BR_DIRECT   = 2'd2,
        BR_INDIRECT = 2'd3
    } branch_type_e;

    // one uBTB line
    // fallthru is the first byte after the block, target the taken destination
    typedef struct packed {
        logic                          valid;
        logic [bpu_cfg_pkg::TAG_W-1:0] tag;
        logic                          taken;
        logic [bpu_cfg_pkg::XLEN-1:0]  fallthru;
        logic [bpu_cfg_pkg::XLEN-1:0]  target;
        branch_type_e                  btype;
    } ubtb_entry_t;

endpackage

/* design/ubtb_if.sv */
`timescale 1ns/100ps

interface ubtb_if #(
    parameter int HIST_LEN = 8
);
    // lookup request, s0
    logic [bpu_cfg_pkg::XLEN-1:0] lookup_pc;
    logic [HIST_LEN-1:0]          lookup_hist;

    // lookup result, combinational
    logic                         hit;
    logic                         taken;
    logic [bpu_cfg_pkg::XLEN-1:0] fallthru;
    logic [bpu_cfg_pkg::XLEN-1:0] target;
    bpu_types_pkg::branch_type_e  btype;

    // training from commit
    logic                         upd_vld;
    logic [bpu_cfg_pkg::XLEN-1:0] upd_pc;
    logic                         upd_taken;
    logic [bpu_cfg_pkg::XLEN-1:0] upd_fallthru;
    logic [bpu_cfg_pkg::XLEN-1:0] upd_target;
    bpu_types_pkg::branch_type_e  upd_btype;
    logic [HIST_LEN-1:0]          upd_hist;

    modport tbl (
        input  lookup_pc, lookup_hist,
        input  upd_vld, upd_pc, upd_taken, upd_fallthru, upd_target, upd_btype, upd_hist,
        output hit, taken, fallthru, target, btype
    );

    modport lookup (
        output lookup_pc,
        input  hit, taken, fallthru, target, btype
    );

    modport hist (
        output lookup_hist, upd_hist,
        input  hit, taken
    );

    modport train (
        output upd_vld, upd_pc, upd_taken, upd_fallthru, upd_target, upd_btype
    );

endinterface

/* design/bpu_pipe_ctrl.sv */
`timescale 1ns/100ps

module bpu_pipe_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic i_squash,
    input  logic i_ftq_rdy,
    output logic o_s1_vld,
    output logic o_s2_vld,
    output logic o_advance
);

    // how deep the pipe is filled
    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        FILL1 = 2'd1,
        FULL  = 2'd2
    } occ_state_e;

    occ_state_e state;
    occ_state_e state_nxt;

    // the ftq back-pressure stalls every stage at once
    assign o_advance = i_ftq_rdy;

    always_comb begin
        state_nxt = state;
        if (i_squash) begin
            state_nxt = EMPTY;
        end else if (o_advance) begin
            case (state)
                EMPTY:   state_nxt = FILL1;
                FILL1:   state_nxt = FULL;
                default: state_nxt = FULL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_s1_vld = (state != EMPTY);
    assign o_s2_vld = (state == FULL);

endmodule

/* design/bpu_hist.sv */
`timescale 1ns/100ps

module bpu_hist #(
    parameter int HIST_LEN = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic i_advance,
    input  logic i_squash,
    input  logic i_commit_vld,
    input  logic i_commit_taken,
    ubtb_if.hist u_if
);

    localparam int LEN_W = $clog2(HIST_LEN + 1);

    logic [HIST_LEN-1:0] arch_hist;
    logic [HIST_LEN-1:0] spec_hist;
    logic [LEN_W-1:0]    spec_len;

    // committed outcomes, newest in bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            arch_hist <= '0;
        end else if (i_commit_vld) begin
            arch_hist <= {arch_hist[HIST_LEN-2:0], i_commit_taken};
        end
    end

    // outcomes predicted since the last squash
    always_ff @(posedge clk) begin
        if (rst || i_squash) begin
            spec_hist <= '0;
            spec_len  <= '0;
        end else if (i_advance && u_if.hit) begin
            spec_hist <= {spec_hist[HIST_LEN-2:0], u_if.taken};
            if (spec_len < LEN_W'(HIST_LEN)) begin
                spec_len <= spec_len + 1'b1;
            end
        end
    end

    // speculative bits sit on top of the committed ones
    assign u_if.lookup_hist = (arch_hist << spec_len) | spec_hist;

    // training indexes with the history before this commit shifts in
    assign u_if.upd_hist = arch_hist;

endmodule

/* design/bpu_ubtb.sv */
`timescale 1ns/100ps

module bpu_ubtb #(
    parameter int UBTB_DEPTH = 32,
    parameter int HIST_LEN   = 8
) (
    input logic clk,
    input logic rst,
    ubtb_if.tbl u_if
);

    localparam int IDX_W = $clog2(UBTB_DEPTH);
    localparam int SHIFT = bpu_cfg_pkg::BLOCK_SHIFT;
    localparam int XLEN  = bpu_cfg_pkg::XLEN;

    if ((1 << IDX_W) != UBTB_DEPTH) begin : g_depth_chk
        $error("UBTB_DEPTH must be a power of two");
    end

    if (HIST_LEN < IDX_W) begin : g_hist_chk
        $error("HIST_LEN must cover the uBTB index width");
    end

    bpu_types_pkg::ubtb_entry_t tbl [UBTB_DEPTH];

    logic [IDX_W-1:0]              rd_idx;
    logic [IDX_W-1:0]              wr_idx;
    bpu_types_pkg::ubtb_entry_t    rd_entry;
    bpu_types_pkg::ubtb_entry_t    wr_entry;
    logic [bpu_cfg_pkg::TAG_W-1:0] rd_tag;
    logic                          rd_hit;

    // block address hashed with global history
    assign rd_idx = u_if.lookup_pc[SHIFT +: IDX_W] ^ u_if.lookup_hist[IDX_W-1:0];
    assign wr_idx = u_if.upd_pc[SHIFT +: IDX_W] ^ u_if.upd_hist[IDX_W-1:0];

    assign rd_entry = tbl[rd_idx];
    assign rd_tag   = u_if.lookup_pc[XLEN-1:SHIFT];
    assign rd_hit   = rd_entry.valid && (rd_entry.tag == rd_tag);

    // a miss falls through to the next sequential block
    assign u_if.hit      = rd_hit;
    assign u_if.taken    = rd_hit ? rd_entry.taken : 1'b0;
    assign u_if.target   = rd_hit ? rd_entry.target : '0;
    assign u_if.btype    = rd_hit ? rd_entry.btype : bpu_types_pkg::BR_NONE;
    assign u_if.fallthru = rd_hit ? rd_entry.fallthru
                                  : u_if.lookup_pc + bpu_cfg_pkg::BLOCK_BYTES;

    assign wr_entry = '{
        valid:    1'b1,
        tag:      u_if.upd_pc[XLEN-1:SHIFT],
        taken:    u_if.upd_taken,
        fallthru: u_if.upd_fallthru,
        target:   u_if.upd_target,
        btype:    u_if.upd_btype
    };

    // only valid bits need clearing, payload is qualified by them
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < UBTB_DEPTH; i++) begin
                tbl[i].valid <= 1'b0;
            end
        end else if (u_if.upd_vld) begin
            tbl[wr_idx] <= wr_entry;
        end
    end

    // commit must describe a non-empty block
    upd_range_chk: assert property (@(posedge clk) disable iff (rst)
        u_if.upd_vld |-> (u_if.upd_fallthru > u_if.upd_pc))
        else $error("training block ends at or before its start");

endmodule

/* design/bpu_pc_gen.sv */
`timescale 1ns/100ps

module bpu_pc_gen #(
    parameter logic [bpu_cfg_pkg::XLEN-1:0] INIT_PC = bpu_cfg_pkg::DEFAULT_INIT_PC
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_squash,
    input  logic [bpu_cfg_pkg::XLEN-1:0] i_squash_pc,
    input  logic                         i_advance,
    input  logic                         i_s1_vld,
    input  logic                         i_s2_vld,
    ubtb_if.lookup                       u_if,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_start,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_end,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_next,
    output logic                         o_taken,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_target,
    output bpu_types_pkg::branch_type_e  o_btype,
    output logic                         o_hit
);

    localparam int XLEN = bpu_cfg_pkg::XLEN;

    logic [XLEN-1:0] base_pc;
    logic [XLEN-1:0] s0_next;

    logic                        s1_hit;
    logic                        s1_taken;
    logic [XLEN-1:0]             s1_pc;
    logic [XLEN-1:0]             s1_fallthru;
    logic [XLEN-1:0]             s1_target;
    bpu_types_pkg::branch_type_e s1_btype;

    logic                        s2_hit;
    logic                        s2_taken;
    logic [XLEN-1:0]             s2_pc;
    logic [XLEN-1:0]             s2_fallthru;
    logic [XLEN-1:0]             s2_target;
    bpu_types_pkg::branch_type_e s2_btype;

    // s0 lookup straight off the base pc
    assign u_if.lookup_pc = base_pc;
    assign s0_next = u_if.taken ? u_if.target : u_if.fallthru;

    always_ff @(posedge clk) begin
        if (rst) begin
            base_pc <= INIT_PC;
        end else if (i_squash) begin
            base_pc <= i_squash_pc;
        end else if (i_advance) begin
            base_pc <= s0_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance && !i_squash) begin
            s1_pc       <= base_pc;
            s1_hit      <= u_if.hit;
            s1_taken    <= u_if.taken;
            s1_fallthru <= u_if.fallthru;
            s1_target   <= u_if.target;
            s1_btype    <= u_if.btype;
        end
    end

    // bubbles in s1 are not copied forward
    always_ff @(posedge clk) begin
        if (i_advance && !i_squash && i_s1_vld) begin
            s2_pc       <= s1_pc;
            s2_hit      <= s1_hit;
            s2_taken    <= s1_taken;
            s2_fallthru <= s1_fallthru;
            s2_target   <= s1_target;
            s2_btype    <= s1_btype;
        end
    end

    // fetch range is [start, end)
    assign o_start  = s2_pc;
    assign o_end    = s2_fallthru;
    assign o_next   = s2_taken ? s2_target : s2_fallthru;
    assign o_taken  = s2_taken;
    assign o_target = s2_target;
    assign o_btype  = s2_btype;
    assign o_hit    = s2_hit;

    block_range_chk: assert property (@(posedge clk) disable iff (rst)
        i_s2_vld |-> (s2_fallthru > s2_pc))
        else $error("presented block is empty or wraps");

endmodule

/* design/bpu_top.sv */
`timescale 1ns/100ps

module bpu_top #(
    parameter int                           UBTB_DEPTH = 32,
    parameter int                           HIST_LEN   = 8,
    parameter logic [bpu_cfg_pkg::XLEN-1:0] INIT_PC    = bpu_cfg_pkg::DEFAULT_INIT_PC
) (
    input  logic                         clk,
    input  logic                         rst,

    // redirect from the backend
    input  logic                         i_squash_vld,
    input  logic [bpu_cfg_pkg::XLEN-1:0] i_squash_pc,

    // resolved block from commit
    input  logic                         i_commit_vld,
    input  logic [bpu_cfg_pkg::XLEN-1:0] i_commit_pc,
    input  logic                         i_commit_taken,
    input  logic [bpu_cfg_pkg::XLEN-1:0] i_commit_fallthru,
    input  logic [bpu_cfg_pkg::XLEN-1:0] i_commit_target,
    input  bpu_types_pkg::branch_type_e  i_commit_btype,

    // prediction to the ftq
    input  logic                         i_ftq_rdy,
    output logic                         o_pred_vld,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_pred_start,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_pred_end,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_pred_next,
    output logic                         o_pred_taken,
    output logic [bpu_cfg_pkg::XLEN-1:0] o_pred_target,
    output bpu_types_pkg::branch_type_e  o_pred_btype,
    output logic                         o_pred_hit
);

    logic s1_vld;
    logic s2_vld;
    logic advance;

    ubtb_if #(.HIST_LEN(HIST_LEN)) u_ubtb_if ();

    // commit port feeds uBTB training directly
    assign u_ubtb_if.upd_vld      = i_commit_vld;
    assign u_ubtb_if.upd_pc       = i_commit_pc;
    assign u_ubtb_if.upd_taken    = i_commit_taken;
    assign u_ubtb_if.upd_fallthru = i_commit_fallthru;
    assign u_ubtb_if.upd_target   = i_commit_target;
    assign u_ubtb_if.upd_btype    = i_commit_btype;

    bpu_pipe_ctrl u_pipe_ctrl (
        .clk       (clk),
        .rst       (rst),
        .i_squash  (i_squash_vld),
        .i_ftq_rdy (i_ftq_rdy),
        .o_s1_vld  (s1_vld),
        .o_s2_vld  (s2_vld),
        .o_advance (advance)
    );

    bpu_hist #(.HIST_LEN(HIST_LEN)) u_hist (
        .clk            (clk),
        .rst            (rst),
        .i_advance      (advance),
        .i_squash       (i_squash_vld),
        .i_commit_vld   (i_commit_vld),
        .i_commit_taken (i_commit_taken),
        .u_if           (u_ubtb_if.hist)
    );

    bpu_ubtb #(
        .UBTB_DEPTH (UBTB_DEPTH),
        .HIST_LEN   (HIST_LEN)
    ) u_ubtb (
        .clk  (clk),
        .rst  (rst),
        .u_if (u_ubtb_if.tbl)
    );

    bpu_pc_gen #(.INIT_PC(INIT_PC)) u_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .i_squash    (i_squash_vld),
        .i_squash_pc (i_squash_pc),
        .i_advance   (advance),
        .i_s1_vld    (s1_vld),
        .i_s2_vld    (s2_vld),
        .u_if        (u_ubtb_if.lookup),
        .o_start     (o_pred_start),
        .o_end       (o_pred_end),
        .o_next      (o_pred_next),
        .o_taken     (o_pred_taken),
        .o_target    (o_pred_target),
        .o_btype     (o_pred_btype),
        .o_hit       (o_pred_hit)
    );

    assign o_pred_vld = s2_vld;

endmodule

/* sim/bpu_tb.sv */
`timescale 1ns/100ps

module bpu_tb;

    localparam int          UBTB_DEPTH = 32;
    localparam int          HIST_LEN   = 8;
    localparam logic [31:0] INIT_PC    = 32'h8000_0000;
    localparam int          IDX_W      = $clog2(UBTB_DEPTH);
    localparam int          SHIFT      = bpu_cfg_pkg::BLOCK_SHIFT;
    localparam int          BLK        = bpu_cfg_pkg::BLOCK_BYTES;
    localparam logic [31:0] CHAIN_PC   = 32'h8000_1000;
    localparam logic [31:0] REGION_PC  = 32'h8000_2000;
    localparam int          P0_BLOCKS  = 12;
    localparam int          P1_RANDOM  = 40;
    localparam int          P1_COMMITS = P1_RANDOM + 16;
    localparam int          P3_BLOCKS  = 40;
    localparam int          P4_BLOCKS  = 30;
    localparam int          TIMEOUT_CYCLES =
        4 * (8 + P0_BLOCKS + P1_COMMITS + P3_BLOCKS + P4_BLOCKS + 8);

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        i_squash_vld;
    logic [31:0]                 i_squash_pc;
    logic                        i_commit_vld;
    logic [31:0]                 i_commit_pc;
    logic                        i_commit_taken;
    logic [31:0]                 i_commit_fallthru;
    logic [31:0]                 i_commit_target;
    bpu_types_pkg::branch_type_e i_commit_btype;
    logic                        i_ftq_rdy;
    logic                        o_pred_vld;
    logic [31:0]                 o_pred_start;
    logic [31:0]                 o_pred_end;
    logic [31:0]                 o_pred_next;
    logic                        o_pred_taken;
    logic [31:0]                 o_pred_target;
    bpu_types_pkg::branch_type_e o_pred_btype;
    logic                        o_pred_hit;

    // reference model state
    logic              m_valid    [UBTB_DEPTH];
    logic [31-SHIFT:0] m_tag      [UBTB_DEPTH];
    logic              m_taken    [UBTB_DEPTH];
    logic [31:0]       m_fallthru [UBTB_DEPTH];
    logic [31:0]       m_target   [UBTB_DEPTH];
    logic [1:0]        m_btype    [UBTB_DEPTH];
    logic [HIST_LEN-1:0] m_arch;
    logic [HIST_LEN-1:0] m_spec;
    int                  m_len;
    logic [31:0]         m_pc;

    // expected fields of the block the DUT should be showing
    logic        exp_ready = 1'b0;
    logic        exp_hit;
    logic        exp_taken;
    logic [31:0] exp_end;
    logic [31:0] exp_next;
    logic [31:0] exp_target;
    logic [31:0] exp_btype;

    int          error_count  = 0;
    int          accept_count = 0;
    int          hit_count    = 0;
    int          cycle_count  = 0;
    logic [31:0] lcg_state    = 32'd38;
    logic        stall_seen   = 1'b0;

    bpu_top #(
        .UBTB_DEPTH (UBTB_DEPTH),
        .HIST_LEN   (HIST_LEN),
        .INIT_PC    (INIT_PC)
    ) uut (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // random block-aligned address inside the training region
    function automatic logic [31:0] region_block();
        logic [15:0] r;
        r = next_rand() % 16'd64;
        return REGION_PC + (32'(r) << SHIFT);
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // next block in order from the model table and history
    task automatic predict_block();
        logic [HIST_LEN-1:0] hist;
        logic [IDX_W-1:0]    idx;
        hist       = (m_arch << m_len) | m_spec;
        idx        = m_pc[SHIFT +: IDX_W] ^ hist[IDX_W-1:0];
        exp_hit    = m_valid[idx] && (m_tag[idx] == m_pc[31:SHIFT]);
        exp_taken  = exp_hit ? m_taken[idx] : 1'b0;
        exp_end    = exp_hit ? m_fallthru[idx] : m_pc + BLK;
        exp_target = exp_hit ? m_target[idx] : 32'd0;
        exp_btype  = exp_hit ? 32'(m_btype[idx]) : 32'd0;
        exp_next   = exp_taken ? exp_target : exp_end;
        exp_ready  = 1'b1;
    endtask

    task automatic compare_block();
        check_field("o_pred_start", o_pred_start, m_pc);
        check_field("o_pred_end", o_pred_end, exp_end);
        check_field("o_pred_next", o_pred_next, exp_next);
        check_field("o_pred_hit", 32'(o_pred_hit), 32'(exp_hit));
        check_field("o_pred_taken", 32'(o_pred_taken), 32'(exp_taken));
        check_field("o_pred_target", o_pred_target, exp_target);
        check_field("o_pred_btype", 32'(o_pred_btype), exp_btype);
    endtask

    // an accepted block moves the model on by one block
    task automatic accept_block();
        if (exp_hit) begin
            m_spec = {m_spec[HIST_LEN-2:0], exp_taken};
            if (m_len < HIST_LEN) begin
                m_len++;
            end
            hit_count++;
        end
        m_pc      = exp_next;
        exp_ready = 1'b0;
        accept_count++;
    endtask

    task automatic send_commit(input logic [31:0] pc, input logic taken,
                               input logic [31:0] ft, input logic [31:0] tgt,
                               input logic [1:0] btype);
        logic [IDX_W-1:0] idx;
        @(posedge clk);
        i_commit_vld      <= 1'b1;
        i_commit_pc       <= pc;
        i_commit_taken    <= taken;
        i_commit_fallthru <= ft;
        i_commit_target   <= tgt;
        i_commit_btype    <= bpu_types_pkg::branch_type_e'(btype);
        // table write indexed by the history before this commit
        idx = pc[SHIFT +: IDX_W] ^ m_arch[IDX_W-1:0];
        m_valid[idx]    = 1'b1;
        m_tag[idx]      = pc[31:SHIFT];
        m_taken[idx]    = taken;
        m_fallthru[idx] = ft;
        m_target[idx]   = tgt;
        m_btype[idx]    = btype;
        m_arch = {m_arch[HIST_LEN-2:0], taken};
    endtask

    task automatic run_blocks(input int n);
        int goal;
        goal = accept_count + n;
        while (accept_count < goal) begin
            @(posedge clk);
            i_ftq_rdy <= (next_rand() % 4) != 0;
        end
    endtask

    task automatic issue_squash(input logic [31:0] pc);
        @(posedge clk);
        i_ftq_rdy    <= 1'b0;
        i_squash_vld <= 1'b1;
        i_squash_pc  <= pc;
        @(posedge clk);
        i_squash_vld <= 1'b0;
    endtask

    // monitor on the falling edge, where inputs and outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (stall_seen) begin
                check_field("o_pred_vld", 32'(o_pred_vld), 32'd1);
            end
            if (i_squash_vld) begin
                m_pc      = i_squash_pc;
                m_spec    = '0;
                m_len     = 0;
                exp_ready = 1'b0;
            end else if (o_pred_vld) begin
                if (!exp_ready) begin
                    predict_block();
                end
                compare_block();
                if (i_ftq_rdy) begin
                    accept_block();
                end
            end
            stall_seen = o_pred_vld && !i_ftq_rdy && !i_squash_vld;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the prediction stream stalled", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] pc;
        logic [31:0] ft;
        logic        tk;
        logic [1:0]  bt;
        rst               = 1'b1;
        i_squash_vld      = 1'b0;
        i_squash_pc       = '0;
        i_commit_vld      = 1'b0;
        i_commit_pc       = '0;
        i_commit_taken    = 1'b0;
        i_commit_fallthru = '0;
        i_commit_target   = '0;
        i_commit_btype    = bpu_types_pkg::BR_NONE;
        i_ftq_rdy         = 1'b0;
        for (int i = 0; i < UBTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        m_arch = '0;
        m_spec = '0;
        m_len  = 0;
        m_pc   = INIT_PC;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_field("o_pred_vld", 32'(o_pred_vld), 32'd0);

        // untrained run from the reset vector
        run_blocks(P0_BLOCKS);

        // training only, pipe stalled
        @(posedge clk);
        i_ftq_rdy <= 1'b0;
        repeat (P1_RANDOM) begin
            pc = region_block();
            ft = pc + BLK * (1 + next_rand() % 4);
            tk = (next_rand() % 4) == 0;
            bt = tk ? 2'(1 + next_rand() % 3) : 2'd1;
            send_commit(pc, tk, ft, region_block(), bt);
        end
        // not-taken chain, second pass lands with a zero history
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < 8; k++) begin
                pc = CHAIN_PC + 32'(k) * 32;
                ft = (k == 7) ? REGION_PC : pc + 32;
                send_commit(pc, 1'b0, ft, region_block(), 2'd1);
            end
        end
        @(posedge clk);
        i_commit_vld <= 1'b0;

        issue_squash(CHAIN_PC);
        run_blocks(P3_BLOCKS);
        assert (hit_count > 0)
        else begin
            $display("no uBTB hit seen after training");
            error_count++;
        end

        // redirect while blocks are still in flight
        issue_squash(CHAIN_PC + 32'h40);
        run_blocks(P4_BLOCKS);
        @(posedge clk);
        i_ftq_rdy <= 1'b0;
        @(posedge clk);
        $display("%0d errors, %0d blocks accepted, %0d hits", error_count, accept_count,
                 hit_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
design/bpu_cfg_pkg.sv
design/bpu_types_pkg.sv
design/ubtb_if.sv
design/bpu_pipe_ctrl.sv
design/bpu_hist.sv
design/bpu_ubtb.sv
design/bpu_pc_gen.sv
design/bpu_top.sv
sim/bpu_tb.sv

/* Bender.yml */
package:
  name: bpu

sources:
  - design/bpu_cfg_pkg.sv
  - design/bpu_types_pkg.sv
  - design/ubtb_if.sv
  - design/bpu_pipe_ctrl.sv
  - design/bpu_hist.sv
  - design/bpu_ubtb.sv
  - design/bpu_pc_gen.sv
  - design/bpu_top.sv
  - target: simulation
    files:
      - sim/bpu_tb.sv
